/* sources.f */
+incdir+.
cnn_pkg.sv
window_feeder.sv
conv_channel.sv
max_pool_drain.sv
cnn_top.sv
tb_cnn_top.sv

/* Makefile */
# Verilator build and run for the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_cnn_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

$(SIM): $(FILELIST) $(shell sed -n 's/^\([^+].*\)$$/\1/p' $(FILELIST)) cnn_defines.svh
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF "$(PASS_MSG)"; then \
		exit 0; \
	else \
		echo "simulation did not report a pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

/* tb_cnn_top.sv */
// Self-checking testbench that streams frames through the convolution engine
`timescale 1ns/1ps
`include "cnn_defines.svh"

module tb_cnn_top;

    localparam int W          = `CNN_IMG_WIDTH;
    localparam int H          = `CNN_IMG_HEIGHT;
    localparam int K          = `CNN_KERNEL_SIZE;
    localparam int CH         = `CNN_CHANNELS;
    localparam int P          = `CNN_POOL_SIZE;
    localparam int NPIX       = W * H;
    localparam int POOL_W     = (W - K + 1) / P;
    localparam int POOL_H     = (H - K + 1) / P;
    localparam int NWORDS     = POOL_W * POOL_H;
    // Six frames at up to four cycles per pixel, plus drain margin
    localparam int MAX_CYCLES = 6 * NPIX * 4 + 200;
    localparam logic [31:0] SEED = 32'h196bec82;

    typedef logic [NPIX-1:0][7:0]    frame_t;
    typedef logic [NWORDS-1:0][31:0] word_set_t;

    logic               clock_i;
    logic               reset_i;
    cnn_pkg::pixel_t    pixel_i;
    logic               pixel_valid_i;
    logic               upstream_stall_o;
    cnn_pkg::out_word_t out_word_o;
    logic               out_valid_o;
    logic               downstream_stall_i;

    logic [31:0] lfsr_q;
    logic [7:0]  stream_q [$];
    logic [31:0] expected_q [$];

    int   cycle;
    int   accepted_count;
    int   taken_count;
    int   check_count;
    int   error_count;
    int   tests_run;
    int   tests_failed;

    // Latency probe for the first pooled word
    bit   lat_armed;
    int   lat_base;
    int   lat_accept;
    int   lat_rise;
    logic out_valid_prev;
    bit   stall_check_on;

    cnn_top uut (
        .clock_i            (clock_i),
        .reset_i            (reset_i),
        .pixel_i            (pixel_i),
        .pixel_valid_i      (pixel_valid_i),
        .upstream_stall_o   (upstream_stall_o),
        .out_word_o         (out_word_o),
        .out_valid_o        (out_valid_o),
        .downstream_stall_i (downstream_stall_i)
    );

    initial begin
        clock_i = 1'b0;
        forever begin
            #5 clock_i = ~clock_i;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    // Convolve, shift, clamp, then take the 2x2 maximum for every pooled position
    function automatic word_set_t reference_words(input frame_t f);
        word_set_t words;
        int        acc;
        int        feat;
        int        best;
        int        pix;
        words = '0;
        for (int pr = 0; pr < POOL_H; pr++) begin
            for (int pc = 0; pc < POOL_W; pc++) begin
                for (int ch = 0; ch < CH; ch++) begin
                    best = 0;
                    for (int dr = 0; dr < P; dr++) begin
                        for (int dc = 0; dc < P; dc++) begin
                            acc = 0;
                            for (int kr = 0; kr < K; kr++) begin
                                for (int kc = 0; kc < K; kc++) begin
                                    pix = int'(f[(P*pr+dr+kr)*W + P*pc+dc+kc]);
                                    acc = acc + pix
                                        * int'($signed(cnn_pkg::KERNEL_WEIGHTS[ch][kr*K+kc]));
                                end
                            end
                            feat = acc >>> `CNN_WEIGHT_Q_SHIFT;
                            if (feat < 0) begin
                                feat = 0;
                            end else if (feat > 255) begin
                                feat = 255;
                            end
                            if (feat > best) begin
                                best = feat;
                            end
                        end
                    end
                    words[pr*POOL_W+pc][ch*8 +: 8] = 8'(best);
                end
            end
        end
        return words;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch %s: got %h expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic queue_frame(input frame_t f);
        word_set_t words;
        words = reference_words(f);
        for (int i = 0; i < NPIX; i++) begin
            stream_q.push_back(f[i]);
        end
        for (int i = 0; i < NWORDS; i++) begin
            expected_q.push_back(words[i]);
        end
    endtask

    // Drive every queued pixel, holding each one until the DUT accepts it
    task automatic send_stream(input bit gaps, input bit stalls);
        int base;
        int total;
        int idx;
        base  = accepted_count;
        total = stream_q.size();
        idx   = 0;
        while (idx < total) begin
            @(negedge clock_i);
            idx = accepted_count - base;
            downstream_stall_i = stalls ? (take_bits(1) != 0) : 1'b0;
            if (idx < total && !(gaps && take_bits(2) == 0)) begin
                pixel_i       = stream_q[idx];
                pixel_valid_i = 1'b1;
            end else begin
                pixel_valid_i = 1'b0;
            end
        end
        stream_q.delete();
    endtask

    // Send the queued frames and wait until every expected word is taken
    task automatic run_frames(input bit gaps, input bit stalls);
        int target;
        target = taken_count + expected_q.size();
        send_stream(gaps, stalls);
        while (taken_count < target) begin
            @(negedge clock_i);
            downstream_stall_i = stalls ? (take_bits(1) != 0) : 1'b0;
        end
        downstream_stall_i = 1'b0;
        repeat (8) @(negedge clock_i);
        check_value("word count", taken_count, target);
        check_value("expected queue size", expected_q.size(), 0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    function automatic frame_t random_frame();
        frame_t f;
        for (int i = 0; i < NPIX; i++) begin
            f[i] = 8'(take_bits(8));
        end
        return f;
    endfunction

    // Sample everything on the rising edge, before the DUT registers update
    always @(posedge clock_i) begin
        cycle = cycle + 1;
        if (!reset_i) begin
            if (stall_check_on) begin
                check_value("upstream_stall_o", upstream_stall_o,
                            out_valid_o && downstream_stall_i);
            end
            if (lat_armed && out_valid_o && !out_valid_prev && lat_rise < 0) begin
                lat_rise = cycle - 1;
            end
            if (pixel_valid_i && !upstream_stall_o) begin
                if (lat_armed && accepted_count - lat_base == 3 * W + 3) begin
                    lat_accept = cycle;
                end
                accepted_count = accepted_count + 1;
            end
            if (out_valid_o && !downstream_stall_i) begin
                taken_count = taken_count + 1;
                if (expected_q.size() == 0) begin
                    $display("output word %h taken while no word was expected", out_word_o);
                    error_count++;
                end else begin
                    check_value("out_word_o", out_word_o, expected_q.pop_front());
                end
            end
        end
        out_valid_prev = out_valid_o;
    end

    initial begin
        wait (cycle >= MAX_CYCLES);
        $display("timeout: run stopped after %0d cycles", cycle);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        frame_t    f;
        word_set_t words;
        int        errs;

        reset_i            = 1'b1;
        pixel_i            = '0;
        pixel_valid_i      = 1'b0;
        downstream_stall_i = 1'b0;
        lfsr_q             = SEED;
        out_valid_prev     = 1'b0;
        lat_accept         = -1;
        lat_rise           = -1;
        repeat (2) @(posedge clock_i);
        @(negedge clock_i);
        reset_i = 1'b0;

        errs = error_count;
        check_value("out_valid_o", out_valid_o, 0);
        check_value("upstream_stall_o", upstream_stall_o, 0);
        report_test("1 reset", errs);

        errs = error_count;
        queue_frame(random_frame());
        run_frames(1'b0, 1'b0);
        report_test("2 random frame", errs);

        // Saturated input hits the upper clamp
        errs = error_count;
        f = '1;
        words = reference_words(f);
        check_value("reference all-255 word", words[0], 32'hFF00_FFFB);
        queue_frame(f);
        run_frames(1'b0, 1'b0);
        report_test("3 all 255 frame", errs);

        // Falling columns push the gradient channel negative
        errs = error_count;
        for (int i = 0; i < NPIX; i++) begin
            f[i] = 8'(240 - 30 * (i % W));
        end
        words = reference_words(f);
        check_value("reference channel 2 byte", words[0][23:16], 0);
        queue_frame(f);
        run_frames(1'b0, 1'b0);
        report_test("4 falling columns", errs);

        errs = error_count;
        queue_frame(random_frame());
        queue_frame(random_frame());
        stall_check_on = 1'b1;
        run_frames(1'b1, 1'b1);
        stall_check_on = 1'b0;
        report_test("5 two frames with gaps and stalls", errs);

        errs = error_count;
        queue_frame(random_frame());
        lat_base   = accepted_count;
        lat_accept = -1;
        lat_rise   = -1;
        lat_armed  = 1'b1;
        run_frames(1'b0, 1'b0);
        lat_armed  = 1'b0;
        check_value("out_valid_o latency", lat_rise - lat_accept, 3);
        report_test("6 first word latency", errs);

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* cnn_top.sv */
// Top level of the streaming convolution and max-pooling engine
`timescale 1ns/1ps
`include "cnn_defines.svh"

module cnn_top (
    input  logic               clock_i,
    input  logic               reset_i,
    input  cnn_pkg::pixel_t    pixel_i,
    input  logic               pixel_valid_i,
    output logic               upstream_stall_o,
    output cnn_pkg::out_word_t out_word_o,
    output logic               out_valid_o,
    input  logic               downstream_stall_i
);

    logic                                 pipe_hold;
    cnn_pkg::window_t                     window;
    logic                                 window_valid;
    cnn_pkg::pixel_t [`CNN_CHANNELS-1:0]  features;
    // All channels run in lockstep, channel 0 qualifies the drain
    logic [`CNN_CHANNELS-1:0]             chan_valid;
    logic                                 feature_valid;

    assign upstream_stall_o = pipe_hold;
    assign feature_valid    = chan_valid[0];

    window_feeder u_feeder (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .hold_i         (pipe_hold),
        .pixel_i        (pixel_i),
        .pixel_valid_i  (pixel_valid_i),
        .window_o       (window),
        .window_valid_o (window_valid)
    );

    for (genvar ch = 0; ch < `CNN_CHANNELS; ch++) begin : g_channel
        conv_channel #(
            .CHANNEL (ch)
        ) u_conv (
            .clock_i         (clock_i),
            .reset_i         (reset_i),
            .hold_i          (pipe_hold),
            .window_i        (window),
            .window_valid_i  (window_valid),
            .feature_o       (features[ch]),
            .feature_valid_o (chan_valid[ch])
        );
    end

    max_pool_drain u_drain (
        .clock_i            (clock_i),
        .reset_i            (reset_i),
        .features_i         (features),
        .feature_valid_i    (feature_valid),
        .downstream_stall_i (downstream_stall_i),
        .out_word_o         (out_word_o),
        .out_valid_o        (out_valid_o),
        .pipe_hold_o        (pipe_hold)
    );

endmodule

/* max_pool_drain.sv */
// Max-pool drain: 2x2 pooling over all channels and output word handshake
`timescale 1ns/1ps
`include "cnn_defines.svh"

module max_pool_drain (
    input  logic                                  clock_i,
    input  logic                                  reset_i,
    input  cnn_pkg::pixel_t [`CNN_CHANNELS-1:0]   features_i,
    input  logic                                  feature_valid_i,
    input  logic                                  downstream_stall_i,
    output cnn_pkg::out_word_t                    out_word_o,
    output logic                                  out_valid_o,
    output logic                                  pipe_hold_o
);

    localparam int CH       = `CNN_CHANNELS;
    localparam int P        = `CNN_POOL_SIZE;
    localparam int FEAT_W   = `CNN_IMG_WIDTH - `CNN_KERNEL_SIZE + 1;
    localparam int FEAT_H   = `CNN_IMG_HEIGHT - `CNN_KERNEL_SIZE + 1;
    localparam int POOL_W   = FEAT_W / P;
    localparam int COL_BITS = $clog2(FEAT_W);
    localparam int ROW_BITS = $clog2(FEAT_H);

    // Feature map position of the incoming value
    logic [COL_BITS-1:0] fcol_q;
    logic [ROW_BITS-1:0] frow_q;

    // Running maxima, one entry per pooled column and channel
    cnn_pkg::pixel_t     pmax_q [CH][POOL_W];
    cnn_pkg::pixel_t     merged [CH];

    cnn_pkg::out_word_t  out_word_q;
    logic                out_valid_q;

    logic                step;
    logic                start_blk;
    logic                end_blk;

    // Freeze everything upstream while a finished word waits
    assign pipe_hold_o = out_valid_q && downstream_stall_i;
    assign step        = feature_valid_i && !pipe_hold_o;

    assign start_blk = (fcol_q % P == 0) && (frow_q % P == 0);
    assign end_blk   = (fcol_q % P == P - 1) && (frow_q % P == P - 1);

    always_comb begin
        for (int c = 0; c < CH; c++) begin
            if (start_blk) begin
                merged[c] = features_i[c];
            end else if (features_i[c] > pmax_q[c][fcol_q / P]) begin
                merged[c] = features_i[c];
            end else begin
                merged[c] = pmax_q[c][fcol_q / P];
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            fcol_q <= '0;
            frow_q <= '0;
        end else if (step) begin
            if (fcol_q == COL_BITS'(FEAT_W - 1)) begin
                fcol_q <= '0;
                frow_q <= (frow_q == ROW_BITS'(FEAT_H - 1)) ? '0 : frow_q + 1'b1;
            end else begin
                fcol_q <= fcol_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (step) begin
            for (int c = 0; c < CH; c++) begin
                pmax_q[c][fcol_q / P] <= merged[c];
            end
            if (end_blk) begin
                for (int c = 0; c < CH; c++) begin
                    out_word_q[c] <= merged[c];
                end
            end
        end
    end

    // A new word may replace one that is taken on the same edge
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (step && end_blk) begin
            out_valid_q <= 1'b1;
        end else if (!downstream_stall_i) begin
            out_valid_q <= 1'b0;
        end
    end

    assign out_word_o  = out_word_q;
    assign out_valid_o = out_valid_q;

    a_word_stable_on_hold : assert property (
        @(posedge clock_i) disable iff (reset_i)
        pipe_hold_o |=> out_valid_o && $stable(out_word_o)
    );

endmodule

/* conv_channel.sv */
// One convolution channel with a 3x3 signed MAC, Q-shift and clamp to pixel range
`timescale 1ns/1ps
`include "cnn_defines.svh"

module conv_channel #(
    parameter int CHANNEL = 0
) (
    input  logic             clock_i,
    input  logic             reset_i,
    input  logic             hold_i,
    input  cnn_pkg::window_t window_i,
    input  logic             window_valid_i,
    output cnn_pkg::pixel_t  feature_o,
    output logic             feature_valid_o
);

    localparam int TAPS    = `CNN_KERNEL_SIZE * `CNN_KERNEL_SIZE;
    localparam int PIX_MAX = (1 << `CNN_PIXEL_BITS) - 1;

    cnn_pkg::conv_sum_t sum;
    cnn_pkg::conv_sum_t scaled;
    cnn_pkg::pixel_t    clamped;
    cnn_pkg::pixel_t    feature_q;
    logic               feature_valid_q;

    // Pixels are zero-extended so the products stay signed
    always_comb begin
        sum = '0;
        for (int k = 0; k < TAPS; k++) begin
            sum = sum + $signed({1'b0, window_i[k]})
                      * cnn_pkg::weight_t'(cnn_pkg::KERNEL_WEIGHTS[CHANNEL][k]);
        end
        scaled = sum >>> `CNN_WEIGHT_Q_SHIFT;
        if (scaled < 0) begin
            clamped = '0;
        end else if (scaled > PIX_MAX) begin
            clamped = '1;
        end else begin
            clamped = scaled[`CNN_PIXEL_BITS-1:0];
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            feature_valid_q <= 1'b0;
        end else if (!hold_i) begin
            feature_valid_q <= window_valid_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!hold_i && window_valid_i) begin
            feature_q <= clamped;
        end
    end

    assign feature_o       = feature_q;
    assign feature_valid_o = feature_valid_q;

    a_valid_low_after_reset : assert property (
        @(posedge clock_i) $fell(reset_i) |=> !feature_valid_o
    );

endmodule

/* window_feeder.sv */
// Window feeder that builds 3x3 pixel windows from a raster pixel stream
`timescale 1ns/1ps
`include "cnn_defines.svh"

module window_feeder (
    input  logic             clock_i,
    input  logic             reset_i,
    input  logic             hold_i,
    input  cnn_pkg::pixel_t  pixel_i,
    input  logic             pixel_valid_i,
    output cnn_pkg::window_t window_o,
    output logic             window_valid_o
);

    localparam int K        = `CNN_KERNEL_SIZE;
    localparam int W        = `CNN_IMG_WIDTH;
    localparam int H        = `CNN_IMG_HEIGHT;
    localparam int COL_BITS = $clog2(W);
    localparam int ROW_BITS = $clog2(H);

    // Position of the next pixel to be accepted
    logic [COL_BITS-1:0] col_q;
    logic [ROW_BITS-1:0] row_q;

    // Input stage
    cnn_pkg::pixel_t     pix_q;
    logic                pix_valid_q;
    logic                win_ok_q;

    // Line buffers with the newest pixel in entry 0
    cnn_pkg::pixel_t     line_q [K-1][W];
    cnn_pkg::window_t    window_q;
    logic                window_valid_q;

    logic                accept;

    assign accept = pixel_valid_i && !hold_i;

    // Capture the pixel and note whether it closes a full window
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            col_q       <= '0;
            row_q       <= '0;
            pix_valid_q <= 1'b0;
            win_ok_q    <= 1'b0;
        end else if (!hold_i) begin
            pix_valid_q <= pixel_valid_i;
            win_ok_q    <= (row_q >= ROW_BITS'(K - 1)) && (col_q >= COL_BITS'(K - 1));
            if (accept) begin
                if (col_q == COL_BITS'(W - 1)) begin
                    col_q <= '0;
                    row_q <= (row_q == ROW_BITS'(H - 1)) ? '0 : row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (!hold_i) begin
            pix_q <= pixel_i;
        end
    end

    // Shift line buffers and slide the window one column left
    always_ff @(posedge clock_i) begin
        if (!hold_i && pix_valid_q) begin
            for (int i = 0; i < K - 1; i++) begin
                for (int j = W - 1; j > 0; j--) begin
                    line_q[i][j] <= line_q[i][j-1];
                end
            end
            line_q[0][0] <= pix_q;
            for (int i = 1; i < K - 1; i++) begin
                line_q[i][0] <= line_q[i-1][W-1];
            end

            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    window_q[r*K+c] <= window_q[r*K+c+1];
                end
            end
            // Oldest line feeds the top row, the live pixel the bottom row
            for (int r = 0; r < K - 1; r++) begin
                window_q[r*K+K-1] <= line_q[K-2-r][W-1];
            end
            window_q[(K-1)*K+K-1] <= pix_q;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            window_valid_q <= 1'b0;
        end else if (!hold_i) begin
            window_valid_q <= pix_valid_q && win_ok_q;
        end
    end

    assign window_o       = window_q;
    assign window_valid_o = window_valid_q;

    // Two pipeline stages separate reset from the first possible window
    a_no_window_after_reset : assert property (
        @(posedge clock_i) $fell(reset_i) |=> !window_valid_o
    );

endmodule

/* cnn_pkg.sv */
// Shared data types and fixed kernel weights for the convolution engine
`include "cnn_defines.svh"

package cnn_pkg;

    // Unsigned pixel, also used for clamped feature values
    typedef logic [`CNN_PIXEL_BITS-1:0] pixel_t;

    // Signed fixed-point weight
    typedef logic signed [`CNN_WEIGHT_BITS-1:0] weight_t;

    // 3x3 window, row-major, element 0 is the top-left pixel
    typedef pixel_t [0:`CNN_KERNEL_SIZE*`CNN_KERNEL_SIZE-1] window_t;

    // Nine 8x9-bit products fit in 19 bits plus sign
    typedef logic signed [19:0] conv_sum_t;

    // One pooled result per channel, channel 0 in the low byte
    typedef pixel_t [`CNN_CHANNELS-1:0] out_word_t;

    // Per-channel kernels, row-major within each channel
    localparam weight_t [0:`CNN_CHANNELS-1][0:`CNN_KERNEL_SIZE*`CNN_KERNEL_SIZE-1]
        KERNEL_WEIGHTS = '{
            // Box average, slightly under unity gain
            '{  7,   7,   7,
                7,   7,   7,
                7,   7,   7},
            // Identity
            '{  0,   0,   0,
                0,  64,   0,
                0,   0,   0},
            // Horizontal gradient, rising to the right
            '{-32,   0,  32,
              -32,   0,  32,
              -32,   0,  32},
            // Vertical smoothing, centre row weighted double
            '{ 16,  16,  16,
               32,  32,  32,
               16,  16,  16}
        };

endpackage

/* cnn_defines.svh */
// Sizing macros for the streaming convolution and max-pooling engine
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// Image geometry in pixels
`define CNN_IMG_WIDTH       8
`define CNN_IMG_HEIGHT      8

// Convolution kernel side and number of output channels
`define CNN_KERNEL_SIZE     3
`define CNN_CHANNELS        4

// Data widths, weights carry 6 fractional bits
`define CNN_PIXEL_BITS      8
`define CNN_WEIGHT_BITS     8
`define CNN_WEIGHT_Q_SHIFT  6

// Side of the max-pooling block
`define CNN_POOL_SIZE       2

`endif
